//--- rtl/lsq_pkg.sv
package lsq_pkg;

    localparam int MEM_QUEUE_DEPTH = 8;                   // power of two
    localparam int MQ_IDX_WIDTH    = $clog2(MEM_QUEUE_DEPTH);
    localparam int ROB_ADDR_WIDTH  = 6;
    localparam int PHYS_REG_WIDTH  = 6;

    typedef enum logic [6:0] {
        op_b_load  = 7'b0000011,
        op_b_store = 7'b0100011
    } opcode_t;

    typedef enum logic [2:0] {
        load_f3_lb  = 3'b000,
        load_f3_lh  = 3'b001,
        load_f3_lw  = 3'b010,
        load_f3_lbu = 3'b100,
        load_f3_lhu = 3'b101
    } load_f3_t;

    typedef enum logic [2:0] {
        store_f3_sb = 3'b000,
        store_f3_sh = 3'b001,
        store_f3_sw = 3'b010
    } store_f3_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_t     opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0]  imm_11_5;
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  imm_4_0;
        opcode_t     opcode;
    } s_type_t;

    // one word seen in load or store layout
    typedef union packed {
        i_type_t i_view;
        s_type_t s_view;
    } inst_u;

    typedef struct packed {
        logic                       valid;
        logic                       addr_ready;
        inst_u                      inst;
        opcode_t                    opcode;
        logic [2:0]                 funct3;
        logic [PHYS_REG_WIDTH-1:0]  pd_s;
        logic [4:0]                 rd_s;
        logic [ROB_ADDR_WIDTH-1:0]  rob_num;
        logic [31:0]                addr;
        logic [1:0]                 shift_bits;   // byte offset in word
        logic [31:0]                store_wdata;
        logic [31:0]                rs1_rdata;
        logic [31:0]                rs2_rdata;
        logic [3:0]                 rmask;        // filled at request time
        logic [3:0]                 wmask;
        logic [31:0]                wdata;
    } lsq_entry_t;

    typedef struct packed {
        logic                       valid;
        logic [ROB_ADDR_WIDTH-1:0]  rob_idx;
        logic [PHYS_REG_WIDTH-1:0]  pd_s;
        logic [4:0]                 rd_s;
        logic [31:0]                rd_v;
        logic [31:0]                inst;
        logic [31:0]                addr;
        logic [3:0]                 rmask;
        logic [3:0]                 wmask;
        logic [31:0]                rdata;
        logic [31:0]                wdata;
        logic [31:0]                rs1_rdata;
        logic [31:0]                rs2_rdata;
    } cdb_t;

    typedef struct packed {
        logic                       valid;
        logic [MQ_IDX_WIDTH-1:0]    idx;
        logic [31:0]                addr;
        logic [31:0]                store_wdata;
        logic [31:0]                rs1_rdata;
        logic [31:0]                rs2_rdata;
    } agu_update_t;

endpackage : lsq_pkg

//--- rtl/address_gen_unit.sv
`timescale 1ns/100ps

module address_gen_unit (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              issue_valid,
    input  logic [lsq_pkg::MQ_IDX_WIDTH-1:0]  issue_idx,
    input  lsq_pkg::inst_u                    issue_inst,
    input  logic [31:0]                       rs1_rdata,
    input  logic [31:0]                       rs2_rdata,
    output lsq_pkg::agu_update_t              agu_update
);
    import lsq_pkg::*;

    logic [31:0] imm;

    // S-type splits the immediate around rd
    always_comb begin
        if (issue_inst.s_view.opcode == op_b_store) begin
            imm = {{20{issue_inst.s_view.imm_11_5[6]}},
                   issue_inst.s_view.imm_11_5,
                   issue_inst.s_view.imm_4_0};
        end else begin
            imm = {{20{issue_inst.i_view.imm_11_0[11]}}, issue_inst.i_view.imm_11_0};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            agu_update.valid <= 1'b0;
        end else begin
            agu_update.valid <= issue_valid;
        end
        agu_update.idx         <= issue_idx;
        agu_update.addr        <= rs1_rdata + imm;   // effective address
        agu_update.store_wdata <= rs2_rdata;
        agu_update.rs1_rdata   <= rs1_rdata;
        agu_update.rs2_rdata   <= rs2_rdata;
    end

endmodule : address_gen_unit

//--- rtl/memory_queue.sv
`timescale 1ns/100ps

module memory_queue #(
    parameter int QUEUE_DEPTH = lsq_pkg::MEM_QUEUE_DEPTH
) (
    input  logic                                clk,
    input  logic                                rst,

    // dispatch
    input  logic                                enqueue_valid,
    input  logic [31:0]                         inst,
    input  logic [lsq_pkg::PHYS_REG_WIDTH-1:0]  phys_reg_in,
    input  logic [lsq_pkg::ROB_ADDR_WIDTH-1:0]  rob_num,

    input  lsq_pkg::agu_update_t                agu_update,
    input  logic [lsq_pkg::ROB_ADDR_WIDTH-1:0]  commited_rob,

    // data memory response
    input  logic [31:0]                         data_in,
    input  logic                                data_valid,

    output logic                                full,
    output logic [$clog2(QUEUE_DEPTH)-1:0]      mem_idx_out,
    output lsq_pkg::cdb_t                       cdb_mem,

    // data memory request
    output logic [31:0]                         d_addr,
    output logic [3:0]                          d_rmask,
    output logic [3:0]                          d_wmask,
    output logic [31:0]                         d_wdata
);
    import lsq_pkg::*;

    localparam int IDX_W = $clog2(QUEUE_DEPTH);

    lsq_entry_t       mem [QUEUE_DEPTH];
    lsq_entry_t       head_entry;
    lsq_entry_t       enq_entry;
    inst_u            inst_dec;

    logic [IDX_W:0]   head, tail;          // msb is the wrap bit
    logic [IDX_W:0]   head_next, tail_next;
    logic [IDX_W-1:0] head_idx;
    logic             cur_full;
    logic             enqueue;
    logic             dequeue;
    logic             mem_req;
    logic [7:0]       ld_byte;
    logic [15:0]      ld_half;

    assign inst_dec   = inst;
    assign head_idx   = head[IDX_W-1:0];
    assign head_entry = mem[head_idx];

    // response cycle retires the head
    assign dequeue   = data_valid;
    assign cur_full  = (head[IDX_W-1:0] == tail[IDX_W-1:0]) && (head[IDX_W] != tail[IDX_W]);
    assign enqueue   = enqueue_valid && (!cur_full || dequeue);
    assign head_next = dequeue ? head + 1'b1 : head;
    assign tail_next = enqueue ? tail + 1'b1 : tail;

    assign full = (head_next[IDX_W-1:0] == tail_next[IDX_W-1:0]) &&
                  (head_next[IDX_W] != tail_next[IDX_W]);
    assign mem_idx_out = tail[IDX_W-1:0];

    assign mem_req = head_entry.valid && head_entry.addr_ready &&
                     (head_entry.rob_num == commited_rob) && !data_valid;

    always_comb begin
        enq_entry         = '0;
        enq_entry.valid   = 1'b1;
        enq_entry.inst    = inst_dec;
        enq_entry.opcode  = inst_dec.i_view.opcode;
        enq_entry.funct3  = inst_dec.i_view.funct3;
        enq_entry.rd_s    = inst_dec.i_view.rd;     // stores drop this at retire
        enq_entry.pd_s    = phys_reg_in;
        enq_entry.rob_num = rob_num;
    end

    // request to data memory
    always_comb begin
        d_addr  = '0;
        d_rmask = '0;
        d_wmask = '0;
        d_wdata = '0;
        if (mem_req) begin
            d_addr = {head_entry.addr[31:2], 2'b00};
            if (head_entry.opcode == op_b_load) begin
                unique case (head_entry.funct3)
                    load_f3_lb, load_f3_lbu: d_rmask = 4'b0001 << head_entry.shift_bits;
                    load_f3_lh, load_f3_lhu: d_rmask = 4'b0011 << head_entry.shift_bits;
                    default:                 d_rmask = 4'b1111;
                endcase
            end else begin
                unique case (head_entry.funct3)
                    store_f3_sb: begin
                        d_wmask = 4'b0001 << head_entry.shift_bits;
                        d_wdata[8*head_entry.shift_bits +: 8] = head_entry.store_wdata[7:0];
                    end
                    store_f3_sh: begin
                        d_wmask = 4'b0011 << head_entry.shift_bits;
                        d_wdata[16*head_entry.shift_bits[1] +: 16] =
                            head_entry.store_wdata[15:0];
                    end
                    default: begin
                        d_wmask = 4'b1111;
                        d_wdata = head_entry.store_wdata;
                    end
                endcase
            end
        end
    end

    assign ld_byte = data_in[8*head_entry.shift_bits +: 8];
    assign ld_half = data_in[16*head_entry.shift_bits[1] +: 16];

    // retire record
    always_comb begin
        cdb_mem = '0;
        if (data_valid) begin
            cdb_mem.valid     = 1'b1;
            cdb_mem.rob_idx   = head_entry.rob_num;
            cdb_mem.pd_s      = head_entry.pd_s;
            cdb_mem.inst      = head_entry.inst;
            cdb_mem.addr      = head_entry.addr;
            cdb_mem.rmask     = head_entry.rmask;
            cdb_mem.wmask     = head_entry.wmask;
            cdb_mem.rs1_rdata = head_entry.rs1_rdata;
            cdb_mem.rs2_rdata = head_entry.rs2_rdata;
            if (head_entry.opcode == op_b_load) begin
                cdb_mem.rd_s  = head_entry.rd_s;
                cdb_mem.rdata = data_in;
                unique case (head_entry.funct3)
                    load_f3_lb:  cdb_mem.rd_v = {{24{ld_byte[7]}}, ld_byte};
                    load_f3_lbu: cdb_mem.rd_v = {24'b0, ld_byte};
                    load_f3_lh:  cdb_mem.rd_v = {{16{ld_half[15]}}, ld_half};
                    load_f3_lhu: cdb_mem.rd_v = {16'b0, ld_half};
                    default:     cdb_mem.rd_v = data_in;
                endcase
            end else begin
                cdb_mem.wdata = head_entry.wdata;   // rd_s, rd_v stay zero
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            for (int i = 0; i < QUEUE_DEPTH; i++) begin
                mem[i].valid      <= 1'b0;
                mem[i].addr_ready <= 1'b0;
            end
        end else begin
            if (agu_update.valid) begin
                mem[agu_update.idx].addr_ready  <= 1'b1;
                mem[agu_update.idx].addr        <= agu_update.addr;
                mem[agu_update.idx].shift_bits  <= agu_update.addr[1:0];
                mem[agu_update.idx].store_wdata <= agu_update.store_wdata;
                mem[agu_update.idx].rs1_rdata   <= agu_update.rs1_rdata;
                mem[agu_update.idx].rs2_rdata   <= agu_update.rs2_rdata;
            end
            if (mem_req) begin
                mem[head_idx].rmask <= d_rmask;  // kept for the retire record
                mem[head_idx].wmask <= d_wmask;
                mem[head_idx].wdata <= d_wdata;
            end
            if (dequeue) begin
                mem[head_idx].valid <= 1'b0;
            end
            // after dequeue so a full-queue refill of the same slot wins
            if (enqueue) begin
                mem[tail[IDX_W-1:0]] <= enq_entry;
            end
            head <= head_next;
            tail <= tail_next;
        end
    end

endmodule : memory_queue

//--- rtl/data_ram.sv
`timescale 1ns/100ps

module data_ram #(
    parameter int DMEM_WORDS = 64
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] d_addr,
    input  logic [3:0]  d_rmask,
    input  logic [3:0]  d_wmask,
    input  logic [31:0] d_wdata,
    output logic [31:0] data_in,
    output logic        data_valid
);

    localparam int WORD_BITS = $clog2(DMEM_WORDS);

    logic [31:0]          ram [DMEM_WORDS];
    logic [WORD_BITS-1:0] word_idx;

    assign word_idx = d_addr[WORD_BITS+1:2];   // upper bits wrap

    always_ff @(posedge clk) begin
        if (rst) begin
            data_valid <= 1'b0;
            for (int i = 0; i < DMEM_WORDS; i++) begin
                ram[i] <= '0;
            end
        end else begin
            data_valid <= (|d_rmask) || (|d_wmask);
            for (int b = 0; b < 4; b++) begin
                if (d_wmask[b]) begin
                    ram[word_idx][8*b +: 8] <= d_wdata[8*b +: 8];
                end
            end
        end
        data_in <= ram[word_idx];   // old word on a store
    end

endmodule : data_ram

//--- rtl/lsu_top.sv
`timescale 1ns/100ps

// QUEUE_DEPTH must equal lsq_pkg::MEM_QUEUE_DEPTH since the AGU index width comes from it
module lsu_top #(
    parameter int QUEUE_DEPTH = lsq_pkg::MEM_QUEUE_DEPTH,
    parameter int DMEM_WORDS  = 64
) (
    input  logic                                clk,
    input  logic                                rst,

    input  logic                                enqueue_valid,
    input  logic [31:0]                         inst,
    input  logic [lsq_pkg::PHYS_REG_WIDTH-1:0]  phys_reg_in,
    input  logic [lsq_pkg::ROB_ADDR_WIDTH-1:0]  rob_num,

    input  logic                                issue_valid,
    input  logic [$clog2(QUEUE_DEPTH)-1:0]      issue_idx,
    input  lsq_pkg::inst_u                      issue_inst,
    input  logic [31:0]                         rs1_rdata,
    input  logic [31:0]                         rs2_rdata,

    input  logic [lsq_pkg::ROB_ADDR_WIDTH-1:0]  commited_rob,

    output logic                                full,
    output logic [$clog2(QUEUE_DEPTH)-1:0]      mem_idx_out,
    output lsq_pkg::cdb_t                       cdb_mem
);
    import lsq_pkg::*;

    agu_update_t agu_update;
    logic [31:0] d_addr;
    logic [3:0]  d_rmask;
    logic [3:0]  d_wmask;
    logic [31:0] d_wdata;
    logic [31:0] data_in;
    logic        data_valid;

    address_gen_unit i_address_gen_unit (
        .clk        (clk),
        .rst        (rst),
        .issue_valid(issue_valid),
        .issue_idx  (issue_idx),
        .issue_inst (issue_inst),
        .rs1_rdata  (rs1_rdata),
        .rs2_rdata  (rs2_rdata),
        .agu_update (agu_update)
    );

    memory_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) i_memory_queue (
        .clk          (clk),
        .rst          (rst),
        .enqueue_valid(enqueue_valid),
        .inst         (inst),
        .phys_reg_in  (phys_reg_in),
        .rob_num      (rob_num),
        .agu_update   (agu_update),
        .commited_rob (commited_rob),
        .data_in      (data_in),
        .data_valid   (data_valid),
        .full         (full),
        .mem_idx_out  (mem_idx_out),
        .cdb_mem      (cdb_mem),
        .d_addr       (d_addr),
        .d_rmask      (d_rmask),
        .d_wmask      (d_wmask),
        .d_wdata      (d_wdata)
    );

    data_ram #(
        .DMEM_WORDS(DMEM_WORDS)
    ) i_data_ram (
        .clk       (clk),
        .rst       (rst),
        .d_addr    (d_addr),
        .d_rmask   (d_rmask),
        .d_wmask   (d_wmask),
        .d_wdata   (d_wdata),
        .data_in   (data_in),
        .data_valid(data_valid)
    );

endmodule : lsu_top

//--- testbench/lsu_tb.sv
`timescale 1ns/100ps

module lsu_tb;
    import lsq_pkg::*;

    localparam int DEPTH      = MEM_QUEUE_DEPTH;
    localparam int IDX_W      = $clog2(DEPTH);
    localparam int DMEM_BYTES = 256;                     // 64 words
    localparam logic [5:0] PARK_ROB = 6'h3f;             // never handed out
    localparam int WAIT_LIMIT = 20;
    localparam int OP_CYCLES  = 6 + WAIT_LIMIT;          // enqueue, issue, commit, park
    localparam int NUM_OPS    = 80;
    localparam int MAX_CYCLES = 8 + NUM_OPS * OP_CYCLES + 200;

    logic                      clk, rst;
    logic                      enqueue_valid, issue_valid, full;
    logic [31:0]               inst, rs1_rdata, rs2_rdata;
    logic [PHYS_REG_WIDTH-1:0] phys_reg_in;
    logic [ROB_ADDR_WIDTH-1:0] rob_num, commited_rob;
    logic [IDX_W-1:0]          issue_idx, mem_idx_out;
    inst_u                     issue_inst;
    cdb_t                      cdb_mem;

    logic [7:0]       model_mem [DMEM_BYTES];
    logic [31:0]      lfsr_state;
    logic [IDX_W-1:0] exp_tail;
    logic [5:0]       rob_ctr;
    int               errors, checks, cycles;
    string            test_name;

    lsu_top #(
        .QUEUE_DEPTH(DEPTH),
        .DMEM_WORDS (DMEM_BYTES / 4)
    ) i_lsu_top (
        .clk          (clk),
        .rst          (rst),
        .enqueue_valid(enqueue_valid),
        .inst         (inst),
        .phys_reg_in  (phys_reg_in),
        .rob_num      (rob_num),
        .issue_valid  (issue_valid),
        .issue_idx    (issue_idx),
        .issue_inst   (issue_inst),
        .rs1_rdata    (rs1_rdata),
        .rs2_rdata    (rs2_rdata),
        .commited_rob (commited_rob),
        .full         (full),
        .mem_idx_out  (mem_idx_out),
        .cdb_mem      (cdb_mem)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles in %s", cycles, test_name);
            $display("Regression failed");
            $finish;
        end
    end

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error %s: %s expected %h actual %h", test_name, what, expected, actual);
        end
    endtask

    // galois lfsr with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
        end
        return r;
    endfunction

    function automatic logic [5:0] next_rob();
        logic [5:0] r;
        r = rob_ctr;
        rob_ctr = (rob_ctr == PARK_ROB - 1) ? 6'd0 : rob_ctr + 6'd1;
        return r;
    endfunction

    function automatic logic [31:0] enc_load(input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, op_b_load};
    endfunction

    function automatic logic [31:0] enc_store(input logic [2:0] f3, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op_b_store};
    endfunction

    // little endian read followed by RV32I extension
    function automatic logic [31:0] model_load(input logic [2:0] f3, input logic [31:0] addr);
        logic [31:0] raw;
        int          size;
        size = 1 << f3[1:0];
        raw = '0;
        for (int b = 0; b < size; b++) begin
            raw[8*b +: 8] = model_mem[(addr + b) % DMEM_BYTES];
        end
        case (size)
            1:       return f3[2] ? {24'b0, raw[7:0]} : {{24{raw[7]}}, raw[7:0]};
            2:       return f3[2] ? {16'b0, raw[15:0]} : {{16{raw[15]}}, raw[15:0]};
            default: return raw;
        endcase
    endfunction

    task automatic model_store(input logic [2:0] f3, input logic [31:0] addr,
                               input logic [31:0] data);
        for (int b = 0; b < (1 << f3[1:0]); b++) begin
            model_mem[(addr + b) % DMEM_BYTES] = data[8*b +: 8];
        end
    endtask

    task automatic enqueue_inst(input logic [31:0] word, input logic [5:0] pd,
                                input logic [5:0] rob, output logic [IDX_W-1:0] slot);
        @(negedge clk);
        check("mem_idx_out", exp_tail, mem_idx_out);
        slot = mem_idx_out;
        @(posedge clk);
        enqueue_valid <= 1'b1;
        inst          <= word;
        phys_reg_in   <= pd;
        rob_num       <= rob;
        @(posedge clk);
        enqueue_valid <= 1'b0;
        exp_tail = exp_tail + 1'b1;   // wraps with the queue
    endtask

    task automatic issue_addr(input logic [IDX_W-1:0] slot, input logic [31:0] word,
                              input logic [31:0] rs1, input logic [31:0] rs2);
        @(posedge clk);
        issue_valid <= 1'b1;
        issue_idx   <= slot;
        issue_inst  <= word;
        rs1_rdata   <= rs1;
        rs2_rdata   <= rs2;
        @(posedge clk);
        issue_valid <= 1'b0;
    endtask

    task automatic commit_and_wait(input logic [5:0] rob, output cdb_t rec, output logic seen);
        int n;
        n = 0;
        seen = 1'b0;
        rec = '0;
        @(posedge clk);
        commited_rob <= rob;
        while (!seen && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
            if (cdb_mem.valid) begin
                seen = 1'b1;
                rec = cdb_mem;
            end
        end
        if (!seen) begin
            errors++;
            $display("%s: rob %0d did not retire within %0d cycles", test_name, rob, WAIT_LIMIT);
        end
        @(posedge clk);
        commited_rob <= PARK_ROB;
    endtask

    // one load or store from dispatch to retire
    // hold counts the cycles with a wrong commit number first
    task automatic mem_op(input logic is_store, input logic [2:0] f3, input logic [31:0] addr,
                          input logic [31:0] data, input int hold);
        logic [5:0]       rob, pd;
        logic [4:0]       rd;
        logic [11:0]      imm;
        logic [31:0]      word, exp_data, base;
        logic [3:0]       exp_mask;
        logic [IDX_W-1:0] slot;
        cdb_t             rec;
        logic             seen;
        rob = next_rob();
        pd = rob ^ 6'h2a;
        rd = rob[4:0] | 5'd1;
        imm = rob[0] ? 12'hff8 : 12'h010;                 // -8 or +16
        base = addr - {{20{imm[11]}}, imm};
        if (is_store) begin
            word = enc_store(f3, 5'd7, 5'd3, imm);
        end else begin
            word = enc_load(f3, rd, 5'd3, imm);
        end
        enqueue_inst(word, pd, rob, slot);
        issue_addr(slot, word, base, data);
        if (hold > 0) begin
            @(posedge clk);
            commited_rob <= rob ^ 6'h01;
            repeat (hold) begin
                @(negedge clk);
                if (cdb_mem.valid) begin
                    errors++;
                    $display("%s: rob %0d retired before it was committed", test_name, rob);
                end
            end
        end
        commit_and_wait(rob, rec, seen);
        if (seen) begin
            case (f3[1:0])
                2'd0:    exp_mask = 4'b0001;
                2'd1:    exp_mask = 4'b0011;
                default: exp_mask = 4'b1111;
            endcase
            check("rob_idx", rob, rec.rob_idx);
            check("inst", word, rec.inst);
            check("addr", addr, rec.addr);
            check("rs1_rdata", base, rec.rs1_rdata);
            check("rs2_rdata", data, rec.rs2_rdata);
            if (is_store) begin
                exp_data = data;
                if (f3[1:0] == 2'd0) exp_data = {24'b0, data[7:0]};
                if (f3[1:0] == 2'd1) exp_data = {16'b0, data[15:0]};
                check("wmask", exp_mask << addr[1:0], rec.wmask);
                check("store rmask", 0, rec.rmask);
                check("wdata", exp_data << (8 * addr[1:0]), rec.wdata);
                check("store rd_v", 0, rec.rd_v);
                check("store rd_s", 0, rec.rd_s);
                model_store(f3, addr, data);
            end else begin
                check("rmask", exp_mask << addr[1:0], rec.rmask);
                check("load wmask", 0, rec.wmask);
                check("rdata", model_load(load_f3_lw, {addr[31:2], 2'b00}), rec.rdata);
                check("rd_v", model_load(f3, addr), rec.rd_v);
                check("pd_s", pd, rec.pd_s);
                check("rd_s", rd, rec.rd_s);
            end
        end
    endtask

    task automatic reset_state();
        test_name = "reset";
        @(negedge clk);
        check("full", 0, full);
        check("cdb valid", 0, cdb_mem.valid);
        check("mem_idx_out", 0, mem_idx_out);
    endtask

    task automatic word_store_load();
        test_name = "store_load_word";
        mem_op(1'b1, store_f3_sw, 32'h20, 32'hdead_beef, 0);
        mem_op(1'b0, load_f3_lw, 32'h20, 32'h0, 0);
    endtask

    task automatic commit_gating();
        test_name = "commit_gate";
        mem_op(1'b1, store_f3_sw, 32'h24, 32'h0bad_f00d, 10);
        mem_op(1'b0, load_f3_lw, 32'h24, 32'h0, 10);
    endtask

    task automatic byte_half_access();
        test_name = "byte_half";
        for (int off = 0; off < 4; off++) begin
            mem_op(1'b1, store_f3_sb, 32'h40 + off, 32'h1234_5600 + 32'h7e + 32'h23 * off, 0);
        end
        for (int off = 0; off < 4; off++) begin
            mem_op(1'b0, load_f3_lb, 32'h40 + off, 32'h0, 0);
            mem_op(1'b0, load_f3_lbu, 32'h40 + off, 32'h0, 0);
        end
        for (int off = 0; off < 4; off += 2) begin
            mem_op(1'b1, store_f3_sh, 32'h48 + off, off ? 32'h5555_7ff1 : 32'hffff_9abc, 0);
            mem_op(1'b0, load_f3_lh, 32'h48 + off, 32'h0, 0);
            mem_op(1'b0, load_f3_lhu, 32'h48 + off, 32'h0, 0);
        end
    endtask

    task automatic fill_in_order();
        logic [5:0]       robs [DEPTH];
        logic [IDX_W-1:0] slots [DEPTH];
        logic [31:0]      word;
        logic [IDX_W-1:0] idx_before;
        logic [5:0]       extra_rob;
        cdb_t             rec;
        logic             seen;
        int               retired;
        test_name = "in_order_retire";
        retired = 0;
        word = enc_load(load_f3_lw, 5'd9, 5'd2, 12'h000);
        for (int k = 0; k < DEPTH; k++) begin
            robs[k] = next_rob();
            enqueue_inst(word, 6'd20 + 6'(k), robs[k], slots[k]);
        end
        @(negedge clk);
        check("full", 1, full);
        idx_before = mem_idx_out;
        extra_rob = next_rob();
        @(posedge clk);
        enqueue_valid <= 1'b1;          // dropped since the queue is full
        rob_num       <= extra_rob;
        @(posedge clk);
        enqueue_valid <= 1'b0;
        @(negedge clk);
        check("full after drop", 1, full);
        check("mem_idx_out after drop", idx_before, mem_idx_out);
        for (int k = DEPTH - 1; k >= 0; k--) begin
            issue_addr(slots[k], word, 32'(4 * k), 32'h0);
        end
        for (int k = 0; k < DEPTH; k++) begin
            commit_and_wait(robs[k], rec, seen);
            if (seen) begin
                retired++;
                check("rob_idx", robs[k], rec.rob_idx);
                check("inst", word, rec.inst);
                check("addr", 32'(4 * k), rec.addr);
                check("rd_v", model_load(load_f3_lw, 32'(4 * k)), rec.rd_v);
            end
        end
        @(posedge clk);
        commited_rob <= extra_rob;
        repeat (10) begin
            @(negedge clk);
            if (cdb_mem.valid) retired++;
        end
        @(posedge clk);
        commited_rob <= PARK_ROB;
        check("retire count", DEPTH, retired);
        @(negedge clk);
        check("full after drain", 0, full);
    endtask

    task automatic random_pairs();
        logic [5:0]  word_idx;
        logic [1:0]  width, off;
        logic        uns;
        logic [31:0] addr, data;
        test_name = "random_pairs";
        for (int i = 0; i < 20; i++) begin
            word_idx = 6'(lfsr_bits(6));
            width = 2'(lfsr_bits(2));
            if (width == 2'd3) width = 2'd2;
            off = 2'(lfsr_bits(2));
            if (width == 2'd1) off[0] = 1'b0;   // aligned halves only
            if (width == 2'd2) off = 2'd0;
            uns = 1'b0;
            if (width != 2'd2) uns = lfsr_bits(1) != 0;
            data = lfsr_bits(32);
            addr = {24'b0, word_idx, off};
            mem_op(1'b1, {1'b0, width}, addr, data, 0);
            mem_op(1'b0, {uns, width}, addr, 32'h0, 0);
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        enqueue_valid = 1'b0;
        inst = '0;
        phys_reg_in = '0;
        rob_num = '0;
        issue_valid = 1'b0;
        issue_idx = '0;
        issue_inst = '0;
        rs1_rdata = '0;
        rs2_rdata = '0;
        commited_rob = PARK_ROB;
        lfsr_state = 32'd42;
        exp_tail = '0;
        rob_ctr = '0;
        errors = 0;
        checks = 0;
        cycles = 0;
        test_name = "init";
        for (int i = 0; i < DMEM_BYTES; i++) begin
            model_mem[i] = 8'h00;         // data memory clears on reset
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        reset_state();
        word_store_load();
        commit_gating();
        byte_half_access();
        fill_in_order();
        random_pairs();
        repeat (4) @(posedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule : lsu_tb

//--- project.f
rtl/lsq_pkg.sv
rtl/address_gen_unit.sv
rtl/memory_queue.sv
rtl/data_ram.sv
rtl/lsu_top.sv
testbench/lsu_tb.sv

//--- run.sh
#!/bin/sh
# build and run the LSU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module lsu_tb -f project.f -o lsu_sim
./obj_dir/lsu_sim > sim.log 2>&1
cat sim.log

if grep -q "Regression failed" sim.log; then
    exit 1
fi
exit 0
